// ==== filelist.f ====
hw/ledger_pkg.sv
hw/account_store.sv
hw/key_table_gen.sv
hw/txn_lookup.sv
hw/txn_verify.sv
hw/txn_commit.sv
hw/ledger_top.sv
testbench/tb_ledger.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ledger testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_ledger \
	-Mdir obj_dir -o sim_ledger > build.log 2>&1 \
	&& ./obj_dir/sim_ledger > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// ==== testbench/tb_ledger.sv ====
// Ledger testbench with a reference model, directed tests, result monitor and watchdog

module tb_ledger
	import ledger_pkg::*;
;

	// Transactions per test summed for the watchdog
	localparam int TEST_TXNS = 8 + 3 + 5 + 5 + 200 + 11;
	localparam int WATCHDOG_CYCLES = TEST_TXNS * 20;

	logic clock;
	logic reset;
	logic txn_valid;
	txn_t txn;
	logic ready;
	logic result_valid;
	result_t result;

	int cycle = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic [31:0] rand_state;

	key_t keys [NUM_ACCOUNTS];
	amount_t balances [NUM_ACCOUNTS];
	result_t exp_q [$];
	int due_q [$]; // Cycle at which each result is due

	ledger_top u_ledger_top (
		.clock(clock),
		.reset(reset),
		.txn_valid(txn_valid),
		.txn(txn),
		.ready(ready),
		.result_valid(result_valid),
		.result(result)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] next_lfsr(input logic [31:0] state);
		if (state[0])
		begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			rand_state = next_lfsr(rand_state);
			value = {value[30:0], rand_state[0]};
		end
		return value;
	endfunction

	// Keys are the low byte of a 16-bit Galois LFSR after each account's step
	task automatic build_keys;
		logic [15:0] state;
		state = 16'hACE1;
		for (int a = 0; a < NUM_ACCOUNTS; a++)
		begin
			if (state[0])
				state = (state >> 1) ^ 16'hB400;
			else
				state = state >> 1;
			keys[a] = state[7:0];
		end
	endtask

	// Expected result that also updates the model balance on a good write
	function automatic result_t expect_result(input txn_t t);
		result_t r;
		amount_t bal;
		logic [8:0] sum;
		bal = balances[t.account];
		sum = {1'b0, bal} + {1'b0, t.amount};
		r.account = t.account;
		r.status = st_ok;
		r.balance = bal;
		if (t.key != keys[t.account])
		begin
			r.status = st_bad_key;
			r.balance = '0;
		end
		else if (t.op == op_withdraw)
		begin
			if (t.amount > bal)
				r.status = st_insufficient;
			else
				r.balance = bal - t.amount;
		end
		else if (t.op == op_deposit)
		begin
			if (sum > 9'd255)
				r.status = st_overflow;
			else
				r.balance = sum[7:0];
		end
		balances[t.account] = (r.status == st_ok) ? r.balance : bal;
		return r;
	endfunction

	task automatic compare_result(input string name, input result_t got, input result_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_status(input string name, input status_t got, input status_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	// Result monitor at the falling edge
	always @(negedge clock)
	begin
		result_t exp;
		int due;
		if (!reset && result_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Extra result on account %0d with no transaction outstanding",
					result.account);
			end
			else
			begin
				exp = exp_q.pop_front();
				due = due_q.pop_front();
				if (cycle != due)
				begin
					errors++;
					$display("Result for account %0d came at cycle %0d instead of %0d",
						result.account, cycle, due);
				end
				compare_status("result.status", result.status, exp.status);
				if (result.status === exp.status)
					compare_result("result", result, exp);
			end
		end
	end

	task automatic send_txn(input op_t op, input account_t account, input amount_t amount,
		input key_t key);
		txn_t t;
		t.op = op;
		t.account = account;
		t.amount = amount;
		t.key = key;
		exp_q.push_back(expect_result(t));
		due_q.push_back(cycle + 3); // Three stages
		txn = t;
		txn_valid = 1'b1;
		@(posedge clock);
		#1;
		txn_valid = 1'b0;
	endtask

	// Reset held for 10 cycles while in-flight results are dropped
	task automatic apply_reset;
		reset = 1'b1;
		txn_valid = 1'b0;
		exp_q.delete();
		due_q.delete();
		for (int a = 0; a < NUM_ACCOUNTS; a++)
			balances[a] = OPENING_BALANCE;
		@(posedge clock);
		@(negedge clock);
		if (ready !== 1'b0)
		begin
			errors++;
			$display("ready stayed high during reset");
		end
		repeat (9) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_ready;
		int waited;
		waited = 0;
		@(negedge clock);
		while (ready !== 1'b1 && waited < 4 * NUM_ACCOUNTS)
		begin
			@(negedge clock);
			waited++;
		end
		if (ready !== 1'b1)
		begin
			errors++;
			$display("ready did not rise after reset");
		end
		@(posedge clock);
		#1;
	endtask

	task automatic drain;
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20)
		begin
			@(posedge clock);
			waited++;
		end
		repeat (2) @(posedge clock); // Room for extra results to show
		#1;
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d results never arrived", exp_q.size());
			exp_q.delete();
			due_q.delete();
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before)
		begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_opening;
		int errs;
		errs = errors;
		wait_ready;
		for (int a = 0; a < NUM_ACCOUNTS; a++)
			send_txn(op_query, account_t'(a), 8'd0, keys[a]);
		drain;
		finish_test("opening balances", errs);
	endtask

	task automatic test_bad_key;
		int errs;
		errs = errors;
		send_txn(op_query, 3'd3, 8'd0, ~keys[3]);
		send_txn(op_withdraw, 3'd3, 8'd10, ~keys[3]); // Must not write
		send_txn(op_query, 3'd3, 8'd0, keys[3]);
		drain;
		finish_test("wrong key", errs);
	endtask

	task automatic test_withdraw;
		int errs;
		errs = errors;
		send_txn(op_withdraw, 3'd1, 8'd30, keys[1]);
		send_txn(op_withdraw, 3'd1, 8'd150, keys[1]);
		send_txn(op_query, 3'd1, 8'd0, keys[1]);
		send_txn(op_withdraw, 3'd2, 8'd100, keys[2]); // Down to zero
		send_txn(op_withdraw, 3'd2, 8'd1, keys[2]);
		drain;
		finish_test("withdrawals", errs);
	endtask

	task automatic test_deposit;
		int errs;
		errs = errors;
		send_txn(op_deposit, 3'd4, 8'd55, keys[4]);
		send_txn(op_deposit, 3'd4, 8'd100, keys[4]); // Exactly 255
		send_txn(op_deposit, 3'd4, 8'd1, keys[4]);
		send_txn(op_deposit, 3'd5, 8'd200, keys[5]);
		send_txn(op_query, 3'd5, 8'd0, keys[5]);
		drain;
		finish_test("deposits", errs);
	endtask

	task automatic test_random;
		int errs;
		account_t account;
		op_t op;
		amount_t amount;
		key_t key;
		logic [1:0] pick;
		errs = errors;
		account = '0;
		for (int n = 0; n < 200; n++)
		begin
			if (rand_bits(1) == 32'd0)
				account = account_t'(rand_bits(3)); // Otherwise reuse the last account
			pick = 2'(rand_bits(2));
			case (pick)
				2'd0: op = op_withdraw;
				2'd1: op = op_deposit;
				default: op = op_query;
			endcase
			amount = amount_t'(rand_bits(7));
			key = keys[account];
			if (rand_bits(2) == 32'd0)
				key = ~key;
			send_txn(op, account, amount, key);
		end
		drain;
		finish_test("random back-to-back", errs);
	endtask

	task automatic test_reset_midrun;
		int errs;
		errs = errors;
		for (int a = 0; a < 3; a++)
			send_txn(op_deposit, account_t'(a), 8'd7, keys[a]);
		apply_reset; // Deposits still in the pipeline
		wait_ready;
		for (int a = 0; a < NUM_ACCOUNTS; a++)
			send_txn(op_query, account_t'(a), 8'd0, keys[a]);
		drain;
		finish_test("reset in mid-run", errs);
	endtask

	initial
	begin
		reset = 1'b1;
		txn_valid = 1'b0;
		txn = '0;
		rand_state = 32'h619;
		build_keys;
		apply_reset;
		test_opening;
		test_bad_key;
		test_withdraw;
		test_deposit;
		test_random;
		test_reset_midrun;
		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== hw/ledger_top.sv ====
// Ledger top level with the key generator, key and balance stores and the three-stage pipeline

module ledger_top
	import ledger_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic txn_valid,
	input txn_t txn,
	output logic ready,
	output logic result_valid,
	output result_t result
);

	// Initialization
	logic init_write;
	account_t init_account;
	key_t init_key;
	logic init_done;

	// Store reads
	account_t read_account;
	key_t stored_key;
	amount_t stored_balance;

	// Balance write port
	logic balance_write;
	account_t balance_account;
	amount_t balance_data;

	// Pipeline
	logic lookup_valid;
	txn_t lookup_txn;
	stage_t verify_stage;
	stage_t commit_stage;

	key_table_gen u_key_table_gen (
		.clock(clock),
		.reset(reset),
		.init_write(init_write),
		.init_account(init_account),
		.init_key(init_key),
		.init_done(init_done)
	);

	account_store #(.entry_t(key_t)) u_key_store (
		.clock(clock),
		.write(init_write),
		.write_account(init_account),
		.write_data(init_key),
		.read_account(read_account),
		.read_data(stored_key)
	);

	account_store #(.entry_t(amount_t)) u_balance_store (
		.clock(clock),
		.write(balance_write),
		.write_account(balance_account),
		.write_data(balance_data),
		.read_account(read_account),
		.read_data(stored_balance)
	);

	txn_lookup u_txn_lookup (
		.clock(clock),
		.reset(reset),
		.init_done(init_done),
		.txn_valid(txn_valid),
		.txn(txn),
		.ready(ready),
		.read_account(read_account),
		.lookup_valid(lookup_valid),
		.lookup_txn(lookup_txn)
	);

	txn_verify u_txn_verify (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_txn(lookup_txn),
		.stored_key(stored_key),
		.stored_balance(stored_balance),
		.commit_stage(commit_stage),
		.verify_stage(verify_stage)
	);

	txn_commit u_txn_commit (
		.clock(clock),
		.reset(reset),
		.init_done(init_done),
		.init_write(init_write),
		.init_account(init_account),
		.verify_stage(verify_stage),
		.commit_stage(commit_stage),
		.balance_write(balance_write),
		.balance_account(balance_account),
		.balance_data(balance_data),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

// ==== hw/txn_commit.sv ====
// Third pipeline stage with the balance write port and the result output

module txn_commit
	import ledger_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init_done,
	input logic init_write,
	input account_t init_account,
	input stage_t verify_stage,
	output stage_t commit_stage,
	output logic balance_write,
	output account_t balance_account,
	output amount_t balance_data,
	output logic result_valid,
	output result_t result
);

	result_t res_q;
	logic write_q;
	logic valid_q;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= verify_stage.valid;
		end
	end

	always_ff @(posedge clock)
	begin
		res_q <= verify_stage.res;
		write_q <= verify_stage.write;
	end

	assign commit_stage = '{res: res_q, write: write_q, valid: valid_q};

	// Generator owns the port until the key table is complete
	always_comb
	begin
		if (!init_done)
		begin
			balance_write = init_write;
			balance_account = init_account;
			balance_data = OPENING_BALANCE;
		end
		else
		begin
			balance_write = valid_q && write_q;
			balance_account = res_q.account;
			balance_data = res_q.balance;
		end
	end

	assign result_valid = valid_q;
	assign result = res_q;

	// Nothing may be in flight while init writes own the balances
	a_idle_during_init: assert property (@(posedge clock) disable iff (reset)
		!init_done |-> !verify_stage.valid && !valid_q);

endmodule

// ==== hw/txn_verify.sv ====
// Second pipeline stage with balance forwarding, key check, arithmetic and status

module txn_verify
	import ledger_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic lookup_valid,
	input txn_t lookup_txn,
	input key_t stored_key,
	input amount_t stored_balance,
	input stage_t commit_stage,
	output stage_t verify_stage
);

	amount_t balance; // Current balance after forwarding
	logic [AMOUNT_BITS:0] sum; // Carry bit flags overflow
	logic key_ok;
	result_t next_res;
	logic next_write;

	result_t stage_res;
	logic stage_write;
	logic stage_valid;

	// Writes still in flight are newer than the store
	// Own register is one transaction back and commit two back
	always_comb
	begin
		if (stage_valid && stage_write && (stage_res.account == lookup_txn.account))
		begin
			balance = stage_res.balance;
		end
		else if (commit_stage.valid && commit_stage.write
			&& (commit_stage.res.account == lookup_txn.account))
		begin
			balance = commit_stage.res.balance;
		end
		else
		begin
			balance = stored_balance; // Write-first store covers three back
		end
	end

	assign key_ok = (lookup_txn.key == stored_key);
	assign sum = {1'b0, balance} + {1'b0, lookup_txn.amount};

	always_comb
	begin
		next_res.account = lookup_txn.account;
		next_res.status = st_ok;
		next_res.balance = balance;
		next_write = 1'b0;
		if (!key_ok)
		begin
			next_res.status = st_bad_key;
			next_res.balance = '0; // Hide the balance
		end
		else if (lookup_txn.op == op_withdraw)
		begin
			if (lookup_txn.amount > balance)
			begin
				next_res.status = st_insufficient;
			end
			else
			begin
				next_res.balance = balance - lookup_txn.amount;
				next_write = 1'b1;
			end
		end
		else if (lookup_txn.op == op_deposit)
		begin
			if (sum[AMOUNT_BITS])
			begin
				next_res.status = st_overflow;
			end
			else
			begin
				next_res.balance = sum[AMOUNT_BITS-1:0];
				next_write = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stage_valid <= 1'b0;
		end
		else
		begin
			stage_valid <= lookup_valid;
		end
	end

	always_ff @(posedge clock)
	begin
		stage_res <= next_res;
		stage_write <= next_write;
	end

	assign verify_stage = '{res: stage_res, write: stage_write, valid: stage_valid};

	// Only a good withdrawal or deposit may touch the balance store
	a_write_needs_ok: assert property (@(posedge clock) disable iff (reset)
		lookup_valid ##1 (stage_valid && stage_write) |->
		(stage_res.status == st_ok) && ($past(lookup_txn.op) != op_query));

endmodule

// ==== hw/txn_lookup.sv ====
// First pipeline stage that accepts transactions after init and addresses both stores

module txn_lookup
	import ledger_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init_done,
	input logic txn_valid,
	input txn_t txn,
	output logic ready,
	output account_t read_account,
	output logic lookup_valid,
	output txn_t lookup_txn
);

	logic accept;

	assign ready = init_done;
	assign accept = txn_valid && ready; // Strobes during init are dropped

	// Store data lands together with lookup_txn
	assign read_account = txn.account;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lookup_valid <= 1'b0;
		end
		else
		begin
			lookup_valid <= accept;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			lookup_txn <= txn;
		end
	end

	// The outside must wait for ready after every reset
	a_valid_only_when_ready: assert property (@(posedge clock) disable iff (reset)
		txn_valid |-> ready);

endmodule

// ==== hw/key_table_gen.sv ====
// Key table generator with a Galois LFSR that walks all accounts after reset and flags init done

module key_table_gen
	import ledger_pkg::*;
(
	input logic clock,
	input logic reset,
	output logic init_write,
	output account_t init_account,
	output key_t init_key,
	output logic init_done
);

	lfsr_t lfsr;
	lfsr_t lfsr_next;
	account_t count; // Next account to write
	logic last_written;

	// Shift right and fold in the mask when a one falls out
	always_comb
	begin
		if (lfsr[0])
		begin
			lfsr_next = (lfsr >> 1) ^ KEY_MASK;
		end
		else
		begin
			lfsr_next = lfsr >> 1;
		end
	end

	assign last_written = init_write && (init_account == account_t'(NUM_ACCOUNTS - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lfsr <= KEY_SEED;
			count <= '0;
			init_write <= 1'b0;
			init_done <= 1'b0;
		end
		else if (!init_done)
		begin
			if (last_written)
			begin
				init_write <= 1'b0;
				init_done <= 1'b1; // Held until the next reset
			end
			else
			begin
				lfsr <= lfsr_next;
				count <= count + 1'b1;
				init_write <= 1'b1;
			end
		end
	end

	// Key is the low byte of the state after this account's step
	always_ff @(posedge clock)
	begin
		if (!init_done && !last_written)
		begin
			init_account <= count;
			init_key <= lfsr_next[KEY_BITS-1:0];
		end
	end

	a_no_write_after_done: assert property (@(posedge clock) disable iff (reset)
		init_done |-> !init_write);

endmodule

// ==== hw/account_store.sv ====
// Per-account storage with one write port and a registered write-first read port

module account_store
	import ledger_pkg::*;
#(
	parameter type entry_t = logic [7:0]
)
(
	input logic clock,
	input logic write,
	input account_t write_account,
	input entry_t write_data,
	input account_t read_account,
	output entry_t read_data
);

	entry_t entries [NUM_ACCOUNTS];

	always_ff @(posedge clock)
	begin
		if (write)
		begin
			entries[write_account] <= write_data;
		end
	end

	// Registered read where a write to the same account wins
	always_ff @(posedge clock)
	begin
		if (write && (write_account == read_account))
		begin
			read_data <= write_data; // Bypass the array
		end
		else
		begin
			read_data <= entries[read_account];
		end
	end

endmodule

// ==== hw/ledger_pkg.sv ====
// Ledger sizes, opening balance, key generator constants, op and status codes, transaction structs

package ledger_pkg;

	localparam int NUM_ACCOUNTS = 8;
	localparam int ACCOUNT_BITS = $clog2(NUM_ACCOUNTS);
	localparam int AMOUNT_BITS = 8;
	localparam int KEY_BITS = 8;
	localparam int LFSR_BITS = 16;

	typedef logic [ACCOUNT_BITS-1:0] account_t;
	typedef logic [AMOUNT_BITS-1:0] amount_t; // Unsigned money and balance
	typedef logic [KEY_BITS-1:0] key_t;
	typedef logic [LFSR_BITS-1:0] lfsr_t;

	localparam amount_t OPENING_BALANCE = 8'd100;

	// Galois LFSR for the key table
	localparam lfsr_t KEY_SEED = 16'hACE1;
	localparam lfsr_t KEY_MASK = 16'hB400;

	typedef enum logic [1:0]
	{
		op_query = 2'd0,
		op_withdraw = 2'd1,
		op_deposit = 2'd2
	} op_t;

	typedef enum logic [1:0]
	{
		st_ok = 2'd0,
		st_bad_key = 2'd1,
		st_insufficient = 2'd2, // Withdrawal larger than balance
		st_overflow = 2'd3 // Deposit sum above 255
	} status_t;

	// 21 bits
	typedef struct packed
	{
		op_t op;
		account_t account;
		amount_t amount;
		key_t key;
	} txn_t;

	// 13 bits
	typedef struct packed
	{
		account_t account;
		status_t status;
		amount_t balance;
	} result_t;

	// Payload between verify and commit
	typedef struct packed
	{
		result_t res;
		logic write; // Balance must be written back
		logic valid;
	} stage_t;

endpackage
